// File: hw/redmule_pkg.sv
// ----------------------------------------
// RedMulE package
// Array sizes, register map, scheduler
// states and the shared packed structs
// ----------------------------------------
`default_nettype none

package redmule_pkg;

  // Array geometry and element widths
  localparam int unsigned WIDTH  = 4;
  localparam int unsigned HEIGHT = 4;
  localparam int unsigned DATA_W = 8;
  localparam int unsigned PROD_W = 2 * DATA_W;
  localparam int unsigned ACC_W  = 32;
  localparam int unsigned ROW_W  = $clog2(WIDTH);

  // Register port
  localparam int unsigned K_W        = 8;
  localparam int unsigned REG_ADDR_W = 8;
  localparam int unsigned BUS_W      = 32;

  localparam logic [REG_ADDR_W-1:0] REG_K_OFFSET       = 'h00;
  localparam logic [REG_ADDR_W-1:0] REG_TRIGGER_OFFSET = 'h54;
  localparam logic [REG_ADDR_W-1:0] REG_STATUS_OFFSET  = 'h0C;

  typedef logic [WIDTH-1:0][DATA_W-1:0]  x_col_t;
  typedef logic [HEIGHT-1:0][DATA_W-1:0] w_row_t;
  typedef logic [HEIGHT-1:0][ACC_W-1:0]  acc_row_t;
  typedef acc_row_t [WIDTH-1:0]          tile_t;

  // wen low means write
  typedef struct packed {
    logic                  req;
    logic                  wen;
    logic [REG_ADDR_W-1:0] addr;
    logic [BUS_W-1:0]      data;
  } periph_req_t;

  typedef struct packed {
    logic             gnt;
    logic             r_valid;
    logic [BUS_W-1:0] r_data;
  } periph_rsp_t;

  typedef struct packed {
    logic [K_W-1:0] k;
  } job_cfg_t;

  typedef struct packed {
    logic             bias_load;
    logic [ROW_W-1:0] bias_row;
    logic             in_valid;
    logic             flush;
  } engine_ctrl_t;

  typedef enum logic [2:0] {
    IDLE,
    LOAD_BIAS,
    COMPUTE,
    DRAIN,
    STORE
  } sched_state_e;

endpackage

`default_nettype wire

// File: hw/redmule_pe.sv
// ----------------------------------------
// RedMulE processing element
// Registered signed multiply followed by
// a wrapping accumulator
// ----------------------------------------
`default_nettype none

module redmule_pe (
  input  wire                            clk_i,
  input  wire                            arst_n_i,
  input  wire [redmule_pkg::DATA_W-1:0]  x_i,
  input  wire [redmule_pkg::DATA_W-1:0]  w_i,
  input  wire [redmule_pkg::ACC_W-1:0]   bias_i,
  input  wire                            bias_load_i,
  input  wire                            valid_i,
  input  wire                            flush_i,
  output logic [redmule_pkg::ACC_W-1:0]  acc_o
);

  logic signed [redmule_pkg::PROD_W-1:0] prod_q;
  logic                                  prod_valid_q;
  logic        [redmule_pkg::ACC_W-1:0]  acc_q;
  logic        [redmule_pkg::ACC_W-1:0]  prod_ext;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      prod_valid_q <= 1'b0;
    end else begin
      prod_valid_q <= valid_i & ~flush_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (valid_i) begin
      prod_q <= $signed(x_i) * $signed(w_i);
    end
  end

  // Sign extend the product to the accumulator width
  assign prod_ext = {{(redmule_pkg::ACC_W - redmule_pkg::PROD_W){prod_q[redmule_pkg::PROD_W-1]}},
                     prod_q};

  always_ff @(posedge clk_i) begin
    if (bias_load_i) begin
      acc_q <= bias_i;
    end else if (prod_valid_q && !flush_i) begin
      acc_q <= acc_q + prod_ext;
    end
  end

  assign acc_o = acc_q;

endmodule

`default_nettype wire

// File: hw/redmule_engine.sv
// ----------------------------------------
// RedMulE engine
// WIDTH x HEIGHT PE array with operand
// broadcast and an in-flight flag
// ----------------------------------------
`default_nettype none

module redmule_engine (
  input  wire                       clk_i,
  input  wire                       arst_n_i,
  input  redmule_pkg::engine_ctrl_t ctrl_i,
  input  redmule_pkg::x_col_t       x_i,
  input  redmule_pkg::w_row_t       w_i,
  input  redmule_pkg::acc_row_t     y_i,
  output redmule_pkg::tile_t        tile_o,
  output logic                      busy_o
);

  // Every PE sees the same valid, so one bit tracks the product stage
  logic inflight_q;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      inflight_q <= 1'b0;
    end else begin
      inflight_q <= ctrl_i.in_valid & ~ctrl_i.flush;
    end
  end

  assign busy_o = inflight_q;

  for (genvar w = 0; w < redmule_pkg::WIDTH; w++) begin : gen_row
    logic row_load;

    // Y row lands only in the selected PE row
    assign row_load = ctrl_i.bias_load & (ctrl_i.bias_row == redmule_pkg::ROW_W'(w));

    for (genvar h = 0; h < redmule_pkg::HEIGHT; h++) begin : gen_col
      redmule_pe i_pe (
        .clk_i       ( clk_i           ),
        .arst_n_i    ( arst_n_i        ),
        .x_i         ( x_i[w]          ),
        .w_i         ( w_i[h]          ),
        .bias_i      ( y_i[h]          ),
        .bias_load_i ( row_load        ),
        .valid_i     ( ctrl_i.in_valid ),
        .flush_i     ( ctrl_i.flush    ),
        .acc_o       ( tile_o[w][h]    )
      );
    end
  end

endmodule

`default_nettype wire

// File: hw/redmule_ctrl.sv
// ----------------------------------------
// RedMulE controller
// Register file with K, trigger and status
// plus the busy flag and done event
// ----------------------------------------
`default_nettype none

module redmule_ctrl (
  input  wire                      clk_i,
  input  wire                      arst_n_i,
  input  redmule_pkg::periph_req_t periph_req_i,
  output redmule_pkg::periph_rsp_t periph_rsp_o,
  input  wire                      done_i,
  output logic                     start_o,
  output redmule_pkg::job_cfg_t    job_cfg_o,
  output logic                     busy_o,
  output logic                     evt_o
);

  logic [redmule_pkg::K_W-1:0]   k_q;
  logic                          busy_q;
  logic                          evt_q;
  logic                          r_valid_q;
  logic [redmule_pkg::BUS_W-1:0] r_data_q;
  logic [redmule_pkg::BUS_W-1:0] r_data_d;
  logic                          wr;
  logic                          rd;

  assign wr = periph_req_i.req & ~periph_req_i.wen;
  assign rd = periph_req_i.req &  periph_req_i.wen;

  // A trigger only counts while idle
  assign start_o = wr & ~busy_q & (periph_req_i.addr == redmule_pkg::REG_TRIGGER_OFFSET);

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      k_q    <= '0;
      busy_q <= 1'b0;
      evt_q  <= 1'b0;
    end else begin
      if (wr && !busy_q && periph_req_i.addr == redmule_pkg::REG_K_OFFSET) begin
        k_q <= periph_req_i.data[redmule_pkg::K_W-1:0];
      end
      if (start_o) begin
        busy_q <= 1'b1;
      end else if (done_i) begin
        busy_q <= 1'b0;
      end
      // Event lines up with the fall of busy
      evt_q <= done_i;
    end
  end

  always_comb begin
    r_data_d = '0;
    if (periph_req_i.addr == redmule_pkg::REG_STATUS_OFFSET) begin
      r_data_d[0] = busy_q;
    end else if (periph_req_i.addr == redmule_pkg::REG_K_OFFSET) begin
      r_data_d[redmule_pkg::K_W-1:0] = k_q;
    end
  end

  // Read data comes back one cycle after the request
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      r_valid_q <= 1'b0;
    end else begin
      r_valid_q <= rd;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rd) begin
      r_data_q <= r_data_d;
    end
  end

  assign periph_rsp_o.gnt     = periph_req_i.req;
  assign periph_rsp_o.r_valid = r_valid_q;
  assign periph_rsp_o.r_data  = r_data_q;

  assign job_cfg_o.k = k_q;
  assign busy_o      = busy_q;
  assign evt_o       = evt_q;

endmodule

`default_nettype wire

// File: hw/redmule_scheduler.sv
// ----------------------------------------
// RedMulE scheduler
// Job FSM: bias load, compute steps,
// pipeline drain and tile store
// ----------------------------------------
`default_nettype none

module redmule_scheduler (
  input  wire                       clk_i,
  input  wire                       arst_n_i,
  input  wire                       start_i,
  input  redmule_pkg::job_cfg_t     job_cfg_i,
  input  wire                       y_valid_i,
  output logic                      y_ready_o,
  input  wire                       x_valid_i,
  output logic                      x_ready_o,
  input  wire                       w_valid_i,
  output logic                      w_ready_o,
  input  wire                       engine_busy_i,
  output redmule_pkg::engine_ctrl_t engine_ctrl_o,
  output logic                      capture_o,
  input  wire                       z_done_i,
  output logic                      done_o
);

  redmule_pkg::sched_state_e state_q;
  redmule_pkg::sched_state_e state_d;

  logic [redmule_pkg::K_W-1:0]   k_last_q;
  logic [redmule_pkg::K_W-1:0]   step_q;
  logic [redmule_pkg::ROW_W-1:0] row_q;
  logic                          y_xfer;
  logic                          step;

  assign y_xfer = (state_q == redmule_pkg::LOAD_BIAS) & y_valid_i;
  // One step pairs an X column with a W row
  assign step   = (state_q == redmule_pkg::COMPUTE) & x_valid_i & w_valid_i;

  always_comb begin
    state_d   = state_q;
    capture_o = 1'b0;
    done_o    = 1'b0;
    case (state_q)
      redmule_pkg::IDLE: begin
        if (start_i) begin
          state_d = redmule_pkg::LOAD_BIAS;
        end
      end
      redmule_pkg::LOAD_BIAS: begin
        if (y_xfer && row_q == redmule_pkg::ROW_W'(redmule_pkg::WIDTH - 1)) begin
          state_d = redmule_pkg::COMPUTE;
        end
      end
      redmule_pkg::COMPUTE: begin
        if (step && step_q == k_last_q) begin
          state_d = redmule_pkg::DRAIN;
        end
      end
      redmule_pkg::DRAIN: begin
        // Last products are in the accumulators once the engine is empty
        if (!engine_busy_i) begin
          capture_o = 1'b1;
          state_d   = redmule_pkg::STORE;
        end
      end
      redmule_pkg::STORE: begin
        if (z_done_i) begin
          done_o  = 1'b1;
          state_d = redmule_pkg::IDLE;
        end
      end
      default: begin
        state_d = redmule_pkg::IDLE;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q  <= redmule_pkg::IDLE;
      k_last_q <= '0;
      step_q   <= '0;
      row_q    <= '0;
    end else begin
      state_q <= state_d;
      if (state_q == redmule_pkg::IDLE && start_i) begin
        // K of zero runs as a single step
        k_last_q <= (job_cfg_i.k == '0) ? '0 : job_cfg_i.k - 1'b1;
        step_q   <= '0;
        row_q    <= '0;
      end else begin
        if (y_xfer) begin
          row_q <= row_q + 1'b1;
        end
        if (step) begin
          step_q <= step_q + 1'b1;
        end
      end
    end
  end

  assign y_ready_o = (state_q == redmule_pkg::LOAD_BIAS);
  assign x_ready_o = (state_q == redmule_pkg::COMPUTE) & w_valid_i;
  assign w_ready_o = (state_q == redmule_pkg::COMPUTE) & x_valid_i;

  assign engine_ctrl_o.bias_load = y_xfer;
  assign engine_ctrl_o.bias_row  = row_q;
  assign engine_ctrl_o.in_valid  = step;
  assign engine_ctrl_o.flush     = (state_q == redmule_pkg::IDLE) & start_i;

endmodule

`default_nettype wire

// File: hw/redmule_z_buffer.sv
// ----------------------------------------
// RedMulE Z buffer
// Holds the finished tile and streams it
// out one row per valid/ready transfer
// ----------------------------------------
`default_nettype none

module redmule_z_buffer (
  input  wire                         clk_i,
  input  wire                         arst_n_i,
  input  wire                         capture_i,
  input  redmule_pkg::tile_t          tile_i,
  output redmule_pkg::acc_row_t       z_o,
  output logic                        z_valid_o,
  input  wire                         z_ready_i,
  output logic                        done_o
);

  redmule_pkg::tile_t            tile_q;
  logic [redmule_pkg::ROW_W-1:0] row_q;
  logic                          valid_q;
  logic                          done_q;
  logic                          xfer;
  logic                          last;

  assign xfer = valid_q & z_ready_i;
  assign last = (row_q == redmule_pkg::ROW_W'(redmule_pkg::WIDTH - 1));

  always_ff @(posedge clk_i) begin
    if (capture_i) begin
      tile_q <= tile_i;
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      row_q   <= '0;
      valid_q <= 1'b0;
      done_q  <= 1'b0;
    end else begin
      done_q <= xfer & last;
      if (capture_i) begin
        row_q   <= '0;
        valid_q <= 1'b1;
      end else if (xfer) begin
        if (last) begin
          valid_q <= 1'b0;
        end else begin
          row_q <= row_q + 1'b1;
        end
      end
    end
  end

  // Row stays put until the sink takes it
  assign z_o       = tile_q[row_q];
  assign z_valid_o = valid_q;
  assign done_o    = done_q;

endmodule

`default_nettype wire

// File: hw/redmule_top.sv
// ----------------------------------------
// RedMulE top level
// Controller, scheduler, PE engine and
// Z buffer for one Z = Y + X*W tile
// ----------------------------------------
`default_nettype none

module redmule_top (
  input  wire                      clk_i,
  input  wire                      arst_n_i,
  input  redmule_pkg::periph_req_t periph_req_i,
  output redmule_pkg::periph_rsp_t periph_rsp_o,
  input  redmule_pkg::x_col_t      x_i,
  input  wire                      x_valid_i,
  output logic                     x_ready_o,
  input  redmule_pkg::w_row_t      w_i,
  input  wire                      w_valid_i,
  output logic                     w_ready_o,
  input  redmule_pkg::acc_row_t    y_i,
  input  wire                      y_valid_i,
  output logic                     y_ready_o,
  output redmule_pkg::acc_row_t    z_o,
  output logic                     z_valid_o,
  input  wire                      z_ready_i,
  output logic                     busy_o,
  output logic                     evt_o
);

  logic                      start;
  logic                      done;
  logic                      capture;
  logic                      z_done;
  logic                      engine_busy;
  redmule_pkg::job_cfg_t     job_cfg;
  redmule_pkg::engine_ctrl_t engine_ctrl;
  redmule_pkg::tile_t        tile;

  redmule_ctrl i_ctrl (
    .clk_i        ( clk_i        ),
    .arst_n_i     ( arst_n_i     ),
    .periph_req_i ( periph_req_i ),
    .periph_rsp_o ( periph_rsp_o ),
    .done_i       ( done         ),
    .start_o      ( start        ),
    .job_cfg_o    ( job_cfg      ),
    .busy_o       ( busy_o       ),
    .evt_o        ( evt_o        )
  );

  redmule_scheduler i_scheduler (
    .clk_i         ( clk_i       ),
    .arst_n_i      ( arst_n_i    ),
    .start_i       ( start       ),
    .job_cfg_i     ( job_cfg     ),
    .y_valid_i     ( y_valid_i   ),
    .y_ready_o     ( y_ready_o   ),
    .x_valid_i     ( x_valid_i   ),
    .x_ready_o     ( x_ready_o   ),
    .w_valid_i     ( w_valid_i   ),
    .w_ready_o     ( w_ready_o   ),
    .engine_busy_i ( engine_busy ),
    .engine_ctrl_o ( engine_ctrl ),
    .capture_o     ( capture     ),
    .z_done_i      ( z_done      ),
    .done_o        ( done        )
  );

  redmule_engine i_engine (
    .clk_i    ( clk_i       ),
    .arst_n_i ( arst_n_i    ),
    .ctrl_i   ( engine_ctrl ),
    .x_i      ( x_i         ),
    .w_i      ( w_i         ),
    .y_i      ( y_i         ),
    .tile_o   ( tile        ),
    .busy_o   ( engine_busy )
  );

  redmule_z_buffer i_z_buffer (
    .clk_i     ( clk_i     ),
    .arst_n_i  ( arst_n_i  ),
    .capture_i ( capture   ),
    .tile_i    ( tile      ),
    .z_o       ( z_o       ),
    .z_valid_o ( z_valid_o ),
    .z_ready_i ( z_ready_i ),
    .done_o    ( z_done    )
  );

endmodule

`default_nettype wire

// File: dv/tb_redmule_top.sv
// ----------------------------------------
// RedMulE testbench
// Random tiles through the register port
// and the streams, checked by assertions
// ----------------------------------------
`default_nettype none

module tb_redmule_top;

  timeunit 1ns;
  timeprecision 100ps;

  localparam int MAX_CYCLES = 4000;
  localparam int MAX_K      = 8;

  logic                     clk_i;
  logic                     arst_n_i;
  redmule_pkg::periph_req_t periph_req;
  redmule_pkg::periph_rsp_t periph_rsp;
  redmule_pkg::x_col_t      x_i;
  logic                     x_valid_i;
  logic                     x_ready_o;
  redmule_pkg::w_row_t      w_i;
  logic                     w_valid_i;
  logic                     w_ready_o;
  redmule_pkg::acc_row_t    y_i;
  logic                     y_valid_i;
  logic                     y_ready_o;
  redmule_pkg::acc_row_t    z_o;
  logic                     z_valid_o;
  logic                     z_ready_i;
  logic                     busy_o;
  logic                     evt_o;

  logic [31:0]           lfsr_q = 32'h28f4_23f4;
  logic                  gaps_on;
  redmule_pkg::x_col_t   x_mat [MAX_K];
  redmule_pkg::w_row_t   w_mat [MAX_K];
  redmule_pkg::acc_row_t y_mat [redmule_pkg::WIDTH];
  int                    x_gap [MAX_K];
  int                    w_gap [MAX_K];
  int                    y_gap [redmule_pkg::WIDTH];
  redmule_pkg::tile_t    exp_tile;
  redmule_pkg::acc_row_t exp_row;
  redmule_pkg::acc_row_t z_hold_q;
  logic [31:0]           exp_rdata;
  logic                  rd_req;
  int                    errors = 0;
  int                    cycles = 0;
  int                    jobs = 0;
  int                    evt_count = 0;
  int                    z_count = 0;
  int                    z_base = 0;
  int                    z_row;

  redmule_top redmule_top_i (
    .clk_i        ( clk_i      ),
    .arst_n_i     ( arst_n_i   ),
    .periph_req_i ( periph_req ),
    .periph_rsp_o ( periph_rsp ),
    .x_i          ( x_i        ),
    .x_valid_i    ( x_valid_i  ),
    .x_ready_o    ( x_ready_o  ),
    .w_i          ( w_i        ),
    .w_valid_i    ( w_valid_i  ),
    .w_ready_o    ( w_ready_o  ),
    .y_i          ( y_i        ),
    .y_valid_i    ( y_valid_i  ),
    .y_ready_o    ( y_ready_o  ),
    .z_o          ( z_o        ),
    .z_valid_o    ( z_valid_o  ),
    .z_ready_i    ( z_ready_i  ),
    .busy_o       ( busy_o     ),
    .evt_o        ( evt_o      )
  );

  always #2 clk_i = ~clk_i;

  assign rd_req  = periph_req.req & periph_req.wen;
  assign z_row   = z_count - z_base;
  assign exp_row = exp_tile[z_row[redmule_pkg::ROW_W-1:0]];

  always @(posedge clk_i) begin
    cycles <= cycles + 1;
    if (cycles >= MAX_CYCLES) begin
      $display("Timeout after %0d cycles with %0d jobs done and %0d errors", cycles, jobs,
               errors);
      $display("test failed");
      $finish;
    end
  end

  always @(posedge clk_i) begin
    z_hold_q <= z_o;
    if (evt_o) begin
      evt_count <= evt_count + 1;
    end
    if (z_valid_o && z_ready_i) begin
      z_count <= z_count + 1;
    end
  end

  // Fibonacci LFSR with taps 32 22 2 1
  function automatic logic next_bit();
    logic fb;
    fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
    lfsr_q = {lfsr_q[30:0], fb};
    return fb;
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      r = {r[30:0], next_bit()};
    end
    return r;
  endfunction

  function automatic int gap_len();
    return gaps_on ? int'(rand_bits(2)) : 0;
  endfunction

  // Sink stalls for about a quarter of the cycles when gaps are on
  initial begin
    z_ready_i = 1'b0;
    forever begin
      @(posedge clk_i);
      #0.5;
      z_ready_i = !gaps_on || (rand_bits(2) != 32'd0);
    end
  end

  reset_idle: assert property (@(posedge clk_i) (!arst_n_i || $rose(arst_n_i)) |->
      !(busy_o || evt_o || z_valid_o || periph_rsp.r_valid || x_ready_o || w_ready_o ||
        y_ready_o))
    else begin
      errors++;
      $display("Fail reset_idle: expected 0000000, actual %b%b%b%b%b%b%b", busy_o, evt_o,
               z_valid_o, periph_rsp.r_valid, x_ready_o, w_ready_o, y_ready_o);
    end

  grant: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      periph_req.req |-> periph_rsp.gnt)
    else begin
      errors++;
      $display("Fail grant: expected gnt 1, actual 0");
    end

  read_latency: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      periph_rsp.r_valid == $past(rd_req))
    else begin
      errors++;
      $display("Fail read_latency: expected r_valid %b, actual %b",
               !$sampled(periph_rsp.r_valid), $sampled(periph_rsp.r_valid));
    end

  read_data: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      periph_rsp.r_valid |-> periph_rsp.r_data == exp_rdata)
    else begin
      errors++;
      $display("Fail read_data: expected %h, actual %h", exp_rdata,
               $sampled(periph_rsp.r_data));
    end

  z_data: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      z_valid_o && z_ready_i |-> z_o == exp_row)
    else begin
      errors++;
      $display("Fail z_data: expected %h, actual %h", $sampled(exp_row), $sampled(z_o));
    end

  z_rows: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      z_valid_o && z_ready_i |-> z_row < redmule_pkg::WIDTH)
    else begin
      errors++;
      $display("Fail z_rows: expected row below %0d, actual %0d", redmule_pkg::WIDTH,
               $sampled(z_row));
    end

  z_hold: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      z_valid_o && !z_ready_i |=> z_valid_o && z_o == z_hold_q)
    else begin
      errors++;
      $display("Fail z_hold: expected %h, actual %h", $sampled(z_hold_q), $sampled(z_o));
    end

  evt_on_fall: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      evt_o |-> $fell(busy_o))
    else begin
      errors++;
      $display("Event pulse seen without busy falling in the same cycle");
    end

  fall_has_evt: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      $fell(busy_o) |-> evt_o)
    else begin
      errors++;
      $display("Busy fell without an event pulse");
    end

  xw_pairing: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      (!x_ready_o || w_valid_i) && (!w_ready_o || x_valid_i))
    else begin
      errors++;
      $display("An X or W ready was high while the other stream had no valid data");
    end

  task automatic next_cycle();
    @(posedge clk_i);
    #0.5;
  endtask

  // Stream 0 is Y, 1 is X and 2 is W
  // Ready is stable from the falling edge on
  task automatic wait_taken(input int s);
    logic taken;
    do begin
      @(negedge clk_i);
      case (s)
        0:       taken = y_ready_o;
        1:       taken = x_ready_o;
        default: taken = w_ready_o;
      endcase
      @(posedge clk_i);
      #0.5;
    end while (!taken);
  endtask

  task automatic reg_write(input logic [7:0] addr, input logic [31:0] data);
    periph_req.req  = 1'b1;
    periph_req.wen  = 1'b0;
    periph_req.addr = addr;
    periph_req.data = data;
    next_cycle();
    periph_req.req = 1'b0;
  endtask

  task automatic reg_read(input logic [7:0] addr, input logic [31:0] expected);
    exp_rdata       = expected;
    periph_req.req  = 1'b1;
    periph_req.wen  = 1'b1;
    periph_req.addr = addr;
    periph_req.data = '0;
    next_cycle();
    periph_req.req = 1'b0;
    next_cycle();
  endtask

  task automatic send_y();
    for (int r = 0; r < redmule_pkg::WIDTH; r++) begin
      repeat (y_gap[r]) next_cycle();
      y_i       = y_mat[r];
      y_valid_i = 1'b1;
      wait_taken(0);
      y_valid_i = 1'b0;
    end
  endtask

  task automatic send_x(input int k);
    for (int s = 0; s < k; s++) begin
      repeat (x_gap[s]) next_cycle();
      x_i       = x_mat[s];
      x_valid_i = 1'b1;
      wait_taken(1);
      x_valid_i = 1'b0;
    end
  endtask

  task automatic send_w(input int k);
    for (int s = 0; s < k; s++) begin
      repeat (w_gap[s]) next_cycle();
      w_i       = w_mat[s];
      w_valid_i = 1'b1;
      wait_taken(2);
      w_valid_i = 1'b0;
    end
  endtask

  function automatic void fill_job(input int k);
    for (int s = 0; s < k; s++) begin
      for (int r = 0; r < redmule_pkg::WIDTH; r++) begin
        x_mat[s][r] = 8'(rand_bits(8));
      end
      for (int c = 0; c < redmule_pkg::HEIGHT; c++) begin
        w_mat[s][c] = 8'(rand_bits(8));
      end
      x_gap[s] = gap_len();
      w_gap[s] = gap_len();
    end
    for (int r = 0; r < redmule_pkg::WIDTH; r++) begin
      y_gap[r] = gap_len();
      for (int c = 0; c < redmule_pkg::HEIGHT; c++) begin
        y_mat[r][c] = rand_bits(32);
      end
    end
  endfunction

  // Z = Y + X*W in signed 32-bit arithmetic that wraps
  function automatic void compute_expected(input int k);
    int  acc;
    byte xv;
    byte wv;
    for (int r = 0; r < redmule_pkg::WIDTH; r++) begin
      for (int c = 0; c < redmule_pkg::HEIGHT; c++) begin
        acc = int'(y_mat[r][c]);
        for (int s = 0; s < k; s++) begin
          xv  = byte'(x_mat[s][r]);
          wv  = byte'(w_mat[s][c]);
          acc = acc + int'(xv) * int'(wv);
        end
        exp_tile[r][c] = acc;
      end
    end
  endfunction

  task automatic run_job(input int k, input logic poke);
    fill_job(k);
    compute_expected(k);
    reg_write(redmule_pkg::REG_K_OFFSET, 32'(k));
    reg_read(redmule_pkg::REG_K_OFFSET, 32'(k));
    reg_read(redmule_pkg::REG_STATUS_OFFSET, 32'd0);
    z_base = z_count;
    reg_write(redmule_pkg::REG_TRIGGER_OFFSET, 32'd1);
    fork
      send_y();
      send_x(k);
      send_w(k);
      begin
        reg_read(redmule_pkg::REG_STATUS_OFFSET, 32'd1);
        // Both writes land while busy and must leave the job alone
        if (poke) begin
          reg_write(redmule_pkg::REG_TRIGGER_OFFSET, 32'd1);
          reg_write(redmule_pkg::REG_K_OFFSET, 32'(k + 2));
          reg_read(redmule_pkg::REG_K_OFFSET, 32'(k));
        end
      end
    join
    do begin
      @(negedge clk_i);
    end while (!evt_o);
    next_cycle();
    jobs++;
    assert (z_row == redmule_pkg::WIDTH)
    else begin
      errors++;
      $display("Fail z_count: expected %0d rows, actual %0d", redmule_pkg::WIDTH, z_row);
    end
    reg_read(redmule_pkg::REG_STATUS_OFFSET, 32'd0);
    reg_read(redmule_pkg::REG_K_OFFSET, 32'(k));
  endtask

  initial begin
    clk_i      = 1'b0;
    arst_n_i   = 1'b0;
    periph_req = '0;
    x_i        = '0;
    x_valid_i  = 1'b0;
    w_i        = '0;
    w_valid_i  = 1'b0;
    y_i        = '0;
    y_valid_i  = 1'b0;
    gaps_on    = 1'b0;
    repeat (3) @(posedge clk_i);
    #0.5;
    arst_n_i = 1'b1;
    next_cycle();
    // Unmapped offset reads as zero
    reg_read(8'h20, 32'd0);
    run_job(1, 1'b0);
    run_job(3, 1'b0);
    run_job(8, 1'b0);
    gaps_on = 1'b1;
    run_job(1, 1'b0);
    run_job(3, 1'b0);
    run_job(8, 1'b0);
    run_job(5, 1'b1);
    gaps_on = 1'b0;
    run_job(2, 1'b1);
    repeat (4) next_cycle();
    assert (evt_count == jobs)
    else begin
      errors++;
      $display("Saw %0d event pulses for %0d jobs", evt_count, jobs);
    end
    $display("Errors: %0d over %0d jobs, %0d Z rows, %0d cycles", errors, jobs, z_count,
             cycles);
    if (errors == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: flist.f
hw/redmule_pkg.sv
hw/redmule_pe.sv
hw/redmule_engine.sv
hw/redmule_ctrl.sv
hw/redmule_scheduler.sv
hw/redmule_z_buffer.sv
hw/redmule_top.sv
dv/tb_redmule_top.sv

// File: Makefile
# Verilator build and run of the RedMulE testbench

VERILATOR ?= verilator
TOP       ?= tb_redmule_top
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the testbench, check $(LOG) for the pass line"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FLIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -qx "test passed" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
